/* common/bb_cfg.svh */
`ifndef BB_CFG_SVH
`define BB_CFG_SVH

// Output score width
`define BB_SCORE_W 8
// Internal team total width
`define BB_TEAM_W 7
// Half-inning and per-play run width
`define BB_RUN_W 5
// Inning number width
`define BB_INNING_W 2
// Outs counter width
`define BB_OUTS_W 2

// Final inning of a game
`define BB_LAST_INNING 3
// Outs that retire a side
`define BB_OUTS_PER_HALF 3

`endif

/* common/bb_pkg.sv */
package bb_pkg;

	//====================================================================
	// Play codes
	//====================================================================

	// One play per cycle, three-bit code
	typedef enum logic [2:0] {
		PLAY_WALK   = 3'd0,
		PLAY_SINGLE = 3'd1,
		PLAY_DOUBLE = 3'd2,
		PLAY_TRIPLE = 3'd3,
		PLAY_HOMER  = 3'd4,
		PLAY_BUNT   = 3'd5,
		PLAY_GROUND = 3'd6,
		PLAY_FLY    = 3'd7
	} play_e;

	//====================================================================
	// Game result
	//====================================================================

	// Code 3 is never produced
	typedef enum logic [1:0] {
		RES_A_WINS = 2'd0,
		RES_B_WINS = 2'd1,
		RES_DRAW   = 2'd2
	} result_e;

	// Runner occupancy
	// Bit 0 first base, bit 1 second, bit 2 third
	typedef logic [2:0] bases_t;

endpackage

/* hw/diamond/bb_run_table.sv */
`include "bb_cfg.svh"

module bb_run_table (
	input  bb_pkg::play_e          play,
	input  bb_pkg::bases_t         bases,
	input  logic [`BB_OUTS_W-1:0]  outs,
	output bb_pkg::bases_t         next_bases,
	output logic [`BB_RUN_W-1:0]   runs,
	output logic [`BB_OUTS_W-1:0]  outs_added
);

	// Runner counts
	logic [1:0]            on_base;
	logic [1:0]            lead_two;
	logic                  two_outs;
	// Result before the retire override
	bb_pkg::bases_t        adv_bases;
	logic [`BB_RUN_W-1:0]  adv_runs;
	logic [`BB_OUTS_W:0]   outs_total;
	logic                  retire;

	assign on_base  = 2'(bases[0]) + 2'(bases[1]) + 2'(bases[2]);
	// Runners on second and third
	assign lead_two = 2'(bases[1]) + 2'(bases[2]);
	assign two_outs = (outs == `BB_OUTS_W'(`BB_OUTS_PER_HALF - 1));

	always_comb begin
		adv_bases  = bases;
		adv_runs   = '0;
		outs_added = '0;
		case (play)
			bb_pkg::PLAY_WALK: begin
				// Forced advance only
				adv_bases[0] = 1'b1;
				adv_bases[1] = bases[1] | bases[0];
				adv_bases[2] = bases[2] | (bases[1] & bases[0]);
				adv_runs     = `BB_RUN_W'(&bases);
			end
			bb_pkg::PLAY_SINGLE: begin
				if (two_outs) begin
					// Runners go two bases
					adv_bases = {bases[0], 1'b0, 1'b1};
					adv_runs  = `BB_RUN_W'(lead_two);
				end else begin
					adv_bases = {bases[1], bases[0], 1'b1};
					adv_runs  = `BB_RUN_W'(bases[2]);
				end
			end
			bb_pkg::PLAY_DOUBLE: begin
				if (two_outs) begin
					// Everyone on base scores
					adv_bases = 3'b010;
					adv_runs  = `BB_RUN_W'(on_base);
				end else begin
					adv_bases = {bases[0], 1'b1, 1'b0};
					adv_runs  = `BB_RUN_W'(lead_two);
				end
			end
			bb_pkg::PLAY_TRIPLE: begin
				adv_bases = 3'b100;
				adv_runs  = `BB_RUN_W'(on_base);
			end
			bb_pkg::PLAY_HOMER: begin
				adv_bases = 3'b000;
				adv_runs  = `BB_RUN_W'(on_base) + `BB_RUN_W'(1);
			end
			bb_pkg::PLAY_BUNT: begin
				// Batter out, runners move up
				adv_bases  = {bases[1], bases[0], 1'b0};
				adv_runs   = `BB_RUN_W'(bases[2]);
				outs_added = `BB_OUTS_W'(1);
			end
			bb_pkg::PLAY_GROUND: begin
				// Double play with first occupied
				adv_bases  = {bases[1], 2'b00};
				adv_runs   = `BB_RUN_W'(bases[2]);
				outs_added = bases[0] ? `BB_OUTS_W'(2) : `BB_OUTS_W'(1);
			end
			bb_pkg::PLAY_FLY: begin
				// Tag up from third only
				adv_bases  = {1'b0, bases[1], bases[0]};
				adv_runs   = `BB_RUN_W'(bases[2]);
				outs_added = `BB_OUTS_W'(1);
			end
		endcase
	end

	// Third out clears the field, no runs count
	assign outs_total = {1'b0, outs} + {1'b0, outs_added};
	assign retire     = (outs_total >= `BB_OUTS_PER_HALF);
	assign next_bases = retire ? 3'b000 : adv_bases;
	assign runs       = retire ? '0 : adv_runs;

endmodule

/* hw/diamond/bb_diamond.sv */
`include "bb_cfg.svh"

module bb_diamond (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               play_valid,
	input  logic [$bits(bb_pkg::play_e)-1:0]   action,
	output logic                               side_retired,
	output logic [`BB_RUN_W-1:0]               half_runs
);

	// Registered play code
	bb_pkg::play_e          act_q;
	// Field state
	bb_pkg::bases_t         bases_q;
	logic [`BB_OUTS_W-1:0]  outs_q;
	// Table results for the play in flight
	bb_pkg::bases_t         next_bases;
	logic [`BB_RUN_W-1:0]   play_runs;
	logic [`BB_OUTS_W-1:0]  outs_added;
	// One extra bit to see the third out
	logic [`BB_OUTS_W:0]    outs_sum;

	//====================================================================
	// Play register
	//====================================================================

	// Sampled every cycle, used only under play_valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			act_q <= bb_pkg::PLAY_WALK;
		end else begin
			act_q <= bb_pkg::play_e'(action);
		end
	end

	bb_run_table u_run_table (
		.play       (act_q),
		.bases      (bases_q),
		.outs       (outs_q),
		.next_bases (next_bases),
		.runs       (play_runs),
		.outs_added (outs_added)
	);

	assign outs_sum = {1'b0, outs_q} + {1'b0, outs_added};

	// High for the whole cycle of the retiring play
	assign side_retired = play_valid && (outs_sum >= `BB_OUTS_PER_HALF);

	//====================================================================
	// Bases, outs and half-inning runs
	//====================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bases_q   <= '0;
			outs_q    <= '0;
			half_runs <= '0;
		end else if (play_valid) begin
			if (side_retired) begin
				// Side retired, field empties
				bases_q   <= '0;
				outs_q    <= '0;
				half_runs <= '0;
			end else begin
				bases_q   <= next_bases;
				outs_q    <= outs_sum[`BB_OUTS_W-1:0];
				half_runs <= half_runs + play_runs;
			end
		end
	end

	// Stored outs never reach a full side
	assert property (@(posedge clk) disable iff (!rst_n)
		outs_q < `BB_OUTS_PER_HALF)
		else $error("stored outs reached %0d", outs_q);

	// Third out scores nobody, so half_runs is final when retired
	assert property (@(posedge clk) disable iff (!rst_n)
		side_retired |-> (play_runs == '0))
		else $error("retiring play added %0d runs", play_runs);

endmodule

/* hw/bb_game_ctrl.sv */
`include "bb_cfg.svh"

module bb_game_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  logic [`BB_INNING_W-1:0] inning,
	input  logic                    half,
	output logic                    play_valid,
	output logic                    bat_half,
	output logic [`BB_INNING_W-1:0] bat_inning,
	output logic                    out_valid
);

	//====================================================================
	// Play strobe and half-inning context
	//====================================================================

	// Lines up with the registered action in the diamond
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			play_valid <= 1'b0;
		end else begin
			play_valid <= in_valid;
		end
	end

	// Context held between games
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bat_half   <= 1'b0;
			bat_inning <= '0;
		end else if (in_valid) begin
			bat_half   <= half;
			bat_inning <= inning;
		end
	end

	// End of burst, same edge as the last team update
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= play_valid && !in_valid;
		end
	end

	// Single-cycle result pulse
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else $error("out_valid held for two cycles");

endmodule

/* hw/bb_scoreboard.sv */
`include "bb_cfg.svh"

module bb_scoreboard (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    side_retired,
	input  logic [`BB_RUN_W-1:0]    half_runs,
	input  logic                    bat_half,
	input  logic [`BB_INNING_W-1:0] bat_inning,
	input  logic                    out_valid,
	output logic [`BB_SCORE_W-1:0]  score_a,
	output logic [`BB_SCORE_W-1:0]  score_b,
	output bb_pkg::result_e         result
);

	// Team totals for the game in progress
	logic [`BB_TEAM_W-1:0] team_a;
	logic [`BB_TEAM_W-1:0] team_b;
	logic [`BB_TEAM_W-1:0] runs_ext;
	logic                  b_counts;

	assign runs_ext = `BB_TEAM_W'(half_runs);

	// Last bottom half counts only while B is not ahead
	assign b_counts = (bat_inning != `BB_INNING_W'(`BB_LAST_INNING)) || (team_a >= team_b);

	//====================================================================
	// Team totals
	//====================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			team_a <= '0;
			team_b <= '0;
		end else if (out_valid) begin
			// Result shown, next game starts clean
			team_a <= '0;
			team_b <= '0;
		end else if (side_retired) begin
			if (!bat_half) begin
				team_a <= team_a + runs_ext;
			end else if (b_counts) begin
				team_b <= team_b + runs_ext;
			end
		end
	end

	// Outputs zero outside the result cycle
	always_comb begin
		score_a = '0;
		score_b = '0;
		result  = bb_pkg::RES_A_WINS;
		if (out_valid) begin
			score_a = `BB_SCORE_W'(team_a);
			score_b = `BB_SCORE_W'(team_b);
			if (team_a > team_b) begin
				result = bb_pkg::RES_A_WINS;
			end else if (team_a < team_b) begin
				result = bb_pkg::RES_B_WINS;
			end else begin
				result = bb_pkg::RES_DRAW;
			end
		end
	end

	// Code 3 is unused
	assert property (@(posedge clk) disable iff (!rst_n) result != 2'd3)
		else $error("illegal result code");

endmodule

/* hw/bb_top.sv */
module bb_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic [1:0] inning,
	input  logic       half,
	input  logic [2:0] action,
	output logic       out_valid,
	output logic [7:0] score_a,
	output logic [7:0] score_b,
	output logic [1:0] result
);

	// Context of the play in flight
	logic       play_valid;
	logic       bat_half;
	logic [1:0] bat_inning;
	// Diamond to scoreboard
	logic       side_retired;
	logic [4:0] half_runs;

	bb_game_ctrl u_game_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.inning     (inning),
		.half       (half),
		.play_valid (play_valid),
		.bat_half   (bat_half),
		.bat_inning (bat_inning),
		.out_valid  (out_valid)
	);

	bb_diamond u_diamond (
		.clk          (clk),
		.rst_n        (rst_n),
		.play_valid   (play_valid),
		.action       (action),
		.side_retired (side_retired),
		.half_runs    (half_runs)
	);

	bb_scoreboard u_scoreboard (
		.clk          (clk),
		.rst_n        (rst_n),
		.side_retired (side_retired),
		.half_runs    (half_runs),
		.bat_half     (bat_half),
		.bat_inning   (bat_inning),
		.out_valid    (out_valid),
		.score_a      (score_a),
		.score_b      (score_b),
		.result       (result)
	);

endmodule

/* dv/bb_tb_model.svh */
`ifndef BB_TB_MODEL_SVH
`define BB_TB_MODEL_SVH

// Random play source
logic [31:0] lcg_state = 32'h7b25;

function automatic int lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return int'(lcg_state[30:16]);
endfunction

// Every runner moves n bases, returns the runners past home
function automatic int move_runners(input logic [2:0] bases, input int n,
		output logic [2:0] moved);
	int runs;
	int dest;
	int i;
	runs = 0;
	moved = 3'b000;
	for (i = 0; i < 3; i++) begin
		if (bases[i]) begin
			dest = i + n;
			if (dest > 2) begin
				runs++;
			end else begin
				moved[dest] = 1'b1;
			end
		end
	end
	return runs;
endfunction

// One play from the scoring rules, returns the runs
function automatic int play_rule(input int play, input logic [2:0] bases, input int outs,
		output logic [2:0] nb, output int added);
	int runs;
	int two_out;
	runs = 0;
	nb = bases;
	added = 0;
	two_out = (outs == `BB_OUTS_PER_HALF - 1) ? 1 : 0;
	case (play)
		0: begin
			// Walk pushes only forced runners
			if (!bases[0]) begin
				nb[0] = 1'b1;
			end else if (!bases[1]) begin
				nb = bases | 3'b011;
			end else if (!bases[2]) begin
				nb = 3'b111;
			end else begin
				runs = 1;
			end
		end
		1: begin
			runs = move_runners(bases, two_out + 1, nb);
			nb[0] = 1'b1;
		end
		2: begin
			// Two outs, everyone on base scores
			runs = move_runners(bases, two_out + 2, nb);
			nb[1] = 1'b1;
		end
		3: begin
			runs = move_runners(bases, 3, nb);
			nb[2] = 1'b1;
		end
		4: begin
			runs = move_runners(bases, 3, nb) + 1;
		end
		5: begin
			runs = move_runners(bases, 1, nb);
			added = 1;
		end
		6: begin
			// Double play when first is occupied
			added = bases[0] ? 2 : 1;
			nb = {bases[1], 2'b00};
			runs = int'(bases[2]);
		end
		default: begin
			// Fly ball, tag up from third
			added = 1;
			nb = {1'b0, bases[1], bases[0]};
			runs = int'(bases[2]);
		end
	endcase
	// Third out, no runs and the field empties
	if (outs + added >= `BB_OUTS_PER_HALF) begin
		nb = 3'b000;
		runs = 0;
	end
	return runs;
endfunction

`endif

/* dv/bb_tb.sv */
`include "bb_cfg.svh"

module bb_tb;

	localparam int DLY = 2;
	// Limit for 34 games of 60 plays at two cycles per play
	localparam int MAX_CYCLES = 34 * 60 * 2;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	logic [1:0] inning;
	logic       half;
	logic [2:0] action;
	logic       out_valid;
	logic [7:0] score_a;
	logic [7:0] score_b;
	logic [1:0] result;

	// Model state
	int         exp_a;
	int         exp_b;
	logic [1:0] exp_res;
	logic [2:0] m_bases;
	int         m_outs;
	int         m_runs;
	bit         half_done;
	bit         directed;
	int         script[$];
	int         errors;
	int         games;
	int         cycles;

	`include "bb_tb_model.svh"

	bb_top dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.inning    (inning),
		.half      (half),
		.action    (action),
		.out_valid (out_valid),
		.score_a   (score_a),
		.score_b   (score_b),
		.result    (result)
	);

	always #20 clk = ~clk;

	assign exp_res = (exp_a > exp_b) ? 2'd0 : ((exp_a < exp_b) ? 2'd1 : 2'd2);

	//====================================================================
	// Checks
	//====================================================================

	// Outputs quiet outside the result cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> (score_a == 8'd0 && score_b == 8'd0 && result == 2'd0))
		else begin
			errors++;
			$display("FAILED at %0t: outputs not zero while out_valid low", $time);
		end

	// End of burst raises out_valid
	assert property (@(posedge clk) disable iff (!rst_n) $fell(in_valid) |=> out_valid)
		else begin
			errors++;
			$display("FAILED at %0t: out_valid missing after burst", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid)
		else begin
			errors++;
			$display("FAILED at %0t: out_valid longer than one cycle", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> ($past(in_valid, 2) && !$past(in_valid)))
		else begin
			errors++;
			$display("FAILED at %0t: out_valid rose without a burst end", $time);
		end

	// Totals against the model
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (score_a == 8'(exp_a) && score_b == 8'(exp_b)))
		else begin
			errors++;
			$display("FAILED at %0t: score %0d-%0d, expected %0d-%0d",
				$time, score_a, score_b, exp_a, exp_b);
		end

	assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> result == exp_res)
		else begin
			errors++;
			$display("FAILED at %0t: result %0d, expected %0d", $time, result, exp_res);
		end

	//====================================================================
	// Stimulus
	//====================================================================

	// Drives one play and advances the model at the same time
	task automatic send_play(input int inn, input int side);
		int play;
		int runs;
		int added;
		logic [2:0] nb;
		if (script.size() > 0) begin
			play = script.pop_front();
		end else if (directed) begin
			play = 7;
		end else begin
			play = lcg_next() % 8;
		end
		@(posedge clk);
		#DLY;
		in_valid = 1'b1;
		inning = 2'(inn);
		half = 1'(side);
		action = 3'(play);
		runs = play_rule(play, m_bases, m_outs, nb, added);
		half_done = (m_outs + added >= `BB_OUTS_PER_HALF);
		if (half_done) begin
			if (side == 0) begin
				exp_a += m_runs;
			end else if (inn != `BB_LAST_INNING || exp_a >= exp_b) begin
				exp_b += m_runs;
			end
			m_bases = 3'b000;
			m_outs = 0;
			m_runs = 0;
		end else begin
			m_bases = nb;
			m_outs += added;
			m_runs += runs;
		end
	endtask

	// Drop in_valid and wait for the result pulse
	task automatic end_game();
		int waited;
		waited = 0;
		@(posedge clk);
		#DLY;
		in_valid = 1'b0;
		action = 3'd0;
		while (out_valid !== 1'b1 && waited < 4) begin
			@(posedge clk);
			#DLY;
			waited++;
		end
		if (out_valid !== 1'b1) begin
			errors++;
			$display("out_valid never rose at the end of game %0d", games);
		end
		@(posedge clk);
		#DLY;
		games++;
	endtask

	task automatic play_game();
		int inn;
		int side;
		exp_a = 0;
		exp_b = 0;
		m_bases = 3'b000;
		m_outs = 0;
		m_runs = 0;
		for (inn = 1; inn <= `BB_LAST_INNING; inn++) begin
			for (side = 0; side < 2; side++) begin
				do begin
					send_play(inn, side);
				end while (!half_done);
			end
		end
		end_game();
	endtask

	// Hang guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		inning = 2'd0;
		half = 1'b0;
		action = 3'd0;
		errors = 0;
		games = 0;
		cycles = 0;
		exp_a = 0;
		exp_b = 0;
		repeat (5) @(posedge clk);
		#DLY;
		rst_n = 1'b1;
		directed = 1'b1;
		// Every code at zero, one and two outs with A winning
		script = '{0, 1, 2, 3, 4, 5, 0, 1, 2, 3, 4, 7, 0, 1, 2, 3, 4, 6,
			6, 7, 5, 7, 0, 6, 0, 6, 7, 7, 5, 7, 7, 7, 7};
		play_game();
		// B leads so the last bottom half runs are ignored
		script = '{7, 7, 7, 4, 7, 7, 7, 7, 7, 7, 4, 7, 7, 7, 7, 7, 7, 4};
		play_game();
		// Draw
		script = '{4, 7, 7, 7, 4};
		play_game();
		// Tie into the last bottom half where the B run counts
		script = '{4, 7, 7, 7, 4, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 7, 4};
		play_game();
		directed = 1'b0;
		repeat (30) play_game();
		repeat (2) @(posedge clk);
		$display("summary: %0d games, %0d errors", games, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+common
+incdir+dv
common/bb_pkg.sv
hw/diamond/bb_run_table.sv
hw/diamond/bb_diamond.sv
hw/bb_game_ctrl.sv
hw/bb_scoreboard.sv
hw/bb_top.sv
dv/bb_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module bb_tb -f list.f -o bb_sim

./obj_dir/bb_sim | tee sim.log

grep -q "all tests passed" sim.log
